/* design/ecc_memory_array.sv */
`timescale 1ns/1ps

module ecc_memory_array (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wr_en,
  input  hamming_pkg::addr_t  wr_addr,
  input  hamming_pkg::block_t wr_block,
  input  hamming_pkg::block_t inject_mask,
  input  logic                rd_en,
  input  hamming_pkg::addr_t  rd_addr,
  output hamming_pkg::block_t rd_block,
  output logic                rd_block_valid
);

  import hamming_pkg::*;

  // Block storage, contents undefined after reset
  block_t mem [0:MEM_DEPTH-1];

  // Write port
  // Set mask bits corrupt the stored copy for error injection
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_block ^ inject_mask;
    end
  end

  // Registered read port
  // Same-edge write to the same address is not visible yet, old value returned
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_block <= mem[rd_addr];
    end
  end

  // Valid follows rd_en by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_block_valid <= 1'b0;
    end else begin
      rd_block_valid <= rd_en;
    end
  end

endmodule

/* design/ecc_memory_top.sv */
`timescale 1ns/1ps

module ecc_memory_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wr_en,
  input  hamming_pkg::addr_t  wr_addr,
  input  hamming_pkg::data_t  wr_data,
  input  hamming_pkg::block_t inject_mask,
  input  logic                rd_en,
  input  hamming_pkg::addr_t  rd_addr,
  output logic                rd_valid,
  output hamming_pkg::data_t  rd_data,
  output logic                err_corrected,
  output logic                err_uncorrectable
);

  import hamming_pkg::*;

  // Encoded write block
  block_t  wr_block;

  // Array read stage
  block_t  arr_block;
  logic    arr_valid;

  // Syndrome stage
  block_t  syn_block;
  parity_t syn_code;
  logic    syn_valid;

  // Write path, purely combinational encode
  // Parity code output is not needed at this level
  hamming_encoder encoder0 (
    .data  (wr_data),
    .code  (),
    .block (wr_block)
  );

  // Stage 1, storage and registered read
  ecc_memory_array array0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_block       (wr_block),
    .inject_mask    (inject_mask),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .rd_block       (arr_block),
    .rd_block_valid (arr_valid)
  );

  // Stage 2, syndrome
  hamming_syndrome syndrome0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (arr_valid),
    .in_block  (arr_block),
    .out_valid (syn_valid),
    .out_block (syn_block),
    .syndrome  (syn_code)
  );

  // Stage 3, correction and data extraction
  hamming_corrector corrector0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (syn_valid),
    .in_block      (syn_block),
    .syndrome      (syn_code),
    .out_valid     (rd_valid),
    .data          (rd_data),
    .corrected     (err_corrected),
    .uncorrectable (err_uncorrectable)
  );

endmodule

/* design/hamming_block_packager.sv */
`timescale 1ns/1ps

module hamming_block_packager (
  input  logic [hamming_pkg::PADDED_DATA_WIDTH-1:0]  data,
  input  hamming_pkg::parity_t                       code,
  output logic [hamming_pkg::PADDED_BLOCK_WIDTH-1:0] block
);

  import hamming_pkg::*;

  // Walk the block positions from 1 upward
  // Power-of-two positions take the next parity bit
  // All other positions take the next data bit, LSB first
  always_comb begin
    int data_index;
    int code_index;
    data_index = 0;
    code_index = 0;
    block      = '0;
    for (int pos = 1; pos <= PADDED_BLOCK_WIDTH; pos++) begin
      // Single bit set means power of two
      if ((pos & (pos - 1)) == 0) begin
        if (code_index < PARITY_WIDTH) begin
          block[pos-1] = code[code_index];
        end
        code_index++;
      end else begin
        if (data_index < PADDED_DATA_WIDTH) begin
          block[pos-1] = data[data_index];
        end
        data_index++;
      end
    end
  end

endmodule

/* design/hamming_corrector.sv */
`timescale 1ns/1ps

module hamming_corrector (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  hamming_pkg::block_t  in_block,
  input  hamming_pkg::parity_t syndrome,
  output logic                 out_valid,
  output hamming_pkg::data_t   data,
  output logic                 corrected,
  output logic                 uncorrectable
);

  import hamming_pkg::*;

  // One-hot flip position, zero when nothing to fix
  block_t flip_mask;
  block_t fixed_block;
  data_t  data_next;
  logic   corrected_next;
  logic   uncorrectable_next;

  // Syndrome value k points at block position k
  always_comb begin
    flip_mask = '0;
    for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
      flip_mask[pos-1] = (int'(syndrome) == pos);
    end
  end

  // Out-of-range syndrome gives an all-zero mask, data passes through raw
  assign fixed_block = in_block ^ flip_mask;

  // Pull data bits from the non-power-of-two positions in order
  always_comb begin
    int data_index;
    data_index = 0;
    data_next  = '0;
    for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        if (data_index < DATA_WIDTH) begin
          data_next[data_index] = fixed_block[pos-1];
        end
        data_index++;
      end
    end
  end

  // Flags are only meaningful with a valid word
  assign corrected_next     = in_valid && (|flip_mask);
  assign uncorrectable_next = in_valid && (int'(syndrome) > BLOCK_WIDTH);

  // Output data register
  always_ff @(posedge clk) begin
    data <= data_next;
  end

  // Valid and status flags
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid     <= 1'b0;
      corrected     <= 1'b0;
      uncorrectable <= 1'b0;
    end else begin
      out_valid     <= in_valid;
      corrected     <= corrected_next;
      uncorrectable <= uncorrectable_next;
    end
  end

endmodule

/* design/hamming_encoder.sv */
`timescale 1ns/1ps

module hamming_encoder (
  input  hamming_pkg::data_t   data,
  output hamming_pkg::parity_t code,
  output hamming_pkg::block_t  block
);

  import hamming_pkg::*;

  // Data zero-extended to the full-length message
  logic [PADDED_DATA_WIDTH-1:0] data_padded;

  // Block with data placed and every parity slot still zero
  logic [PADDED_BLOCK_WIDTH-1:0] data_block;

  // Final full-length block with parity filled in
  logic [PADDED_BLOCK_WIDTH-1:0] block_padded;

  // Computed parity code
  parity_t parity;

  // Upper message bits are unused, so zero
  assign data_padded = {{(PADDED_DATA_WIDTH - DATA_WIDTH){1'b0}}, data};

  // First pass places the data only
  // Parity slots are zero so the XOR below needs no self-exclusion
  hamming_block_packager data_packer (
    .data  (data_padded),
    .code  ({PARITY_WIDTH{1'b0}}),
    .block (data_block)
  );

  // Parity bit i covers every position whose index has bit i set
  always_comb begin
    parity = '0;
    for (int i = 0; i < PARITY_WIDTH; i++) begin
      for (int pos = 1; pos <= PADDED_BLOCK_WIDTH; pos++) begin
        if (pos[i]) begin
          parity[i] = parity[i] ^ data_block[pos-1];
        end
      end
    end
  end

  // Second pass inserts the parity at the power-of-two positions
  hamming_block_packager block_packer (
    .data  (data_padded),
    .code  (parity),
    .block (block_padded)
  );

  assign code = parity;

  // Padded tail positions hold only zero data, drop them
  assign block = block_padded[BLOCK_WIDTH-1:0];

endmodule

/* design/hamming_pkg.sv */
`include "hamming.svh"

package hamming_pkg;

  // User data width
  localparam int DATA_WIDTH = 8;

  // Parity bits needed to protect DATA_WIDTH bits
  localparam int PARITY_WIDTH = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH);

  // Stored block, data plus parity
  localparam int BLOCK_WIDTH = DATA_WIDTH + PARITY_WIDTH;

  // Data width the parity count could cover if the block were full length
  localparam int PADDED_DATA_WIDTH = `GET_HAMMING_DATA_WIDTH(PARITY_WIDTH);

  // Full-length Hamming block, 2**PARITY_WIDTH - 1 positions
  localparam int PADDED_BLOCK_WIDTH = PADDED_DATA_WIDTH + PARITY_WIDTH;

  // Memory geometry
  localparam int ADDR_WIDTH = 4;
  localparam int MEM_DEPTH  = 2 ** ADDR_WIDTH;

  // User data word
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Parity code, also reused for the syndrome
  typedef logic [PARITY_WIDTH-1:0] parity_t;

  // Hamming block as stored in the array
  // Bit k of the vector is block position k+1
  typedef logic [BLOCK_WIDTH-1:0] block_t;

  // Word address into the array
  typedef logic [ADDR_WIDTH-1:0] addr_t;

endpackage

/* design/hamming_syndrome.sv */
`timescale 1ns/1ps

module hamming_syndrome (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  hamming_pkg::block_t  in_block,
  output logic                 out_valid,
  output hamming_pkg::block_t  out_block,
  output hamming_pkg::parity_t syndrome
);

  import hamming_pkg::*;

  // Combinational syndrome of the incoming block
  parity_t syndrome_next;

  // Bit i is the XOR over every position with index bit i set
  // Stored parity bit sits in that set, so the result is recomputed XOR stored
  // Zero for a clean block, else the index of a single flipped position
  always_comb begin
    syndrome_next = '0;
    for (int i = 0; i < PARITY_WIDTH; i++) begin
      for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
        if (pos[i]) begin
          syndrome_next[i] = syndrome_next[i] ^ in_block[pos-1];
        end
      end
    end
  end

  // Payload registers
  // Block and syndrome travel together into the corrector
  always_ff @(posedge clk) begin
    out_block <= in_block;
    syndrome  <= syndrome_next;
  end

  // Stage valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

endmodule

/* dv/ecc_memory_tb.sv */
`timescale 1ns/1ps

module ecc_memory_tb;

  import hamming_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_DOUBLE   = 24;
  localparam int NUM_DRAINS   = 7;
  localparam int unsigned SEED = 32'h1cc5e888;

  // Rough cycle budget of all tests, drains allowed four cycles each
  localparam int NUM_OPS = 4 * MEM_DEPTH + 2 * BLOCK_WIDTH + 2 * NUM_DOUBLE + 3
                         + 2 * RESET_CYCLES + 4 * NUM_DRAINS;

  logic    clk;
  logic    rst_n;
  logic    wr_en;
  addr_t   wr_addr;
  data_t   wr_data;
  block_t  inject_mask;
  logic    rd_en;
  addr_t   rd_addr;
  logic    rd_valid;
  data_t   rd_data;
  logic    err_corrected;
  logic    err_uncorrectable;

  // Stored blocks as the DUT should hold them, mask applied
  block_t shadow_mem [0:MEM_DEPTH-1];

  // Expected {uncorrectable, corrected, data} and the cycle it is due
  logic [DATA_WIDTH+1:0] exp_q [$];
  int                    due_q [$];

  // Rising edges seen so far
  int cycle_count;

  ecc_memory_top dut0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .wr_en             (wr_en),
    .wr_addr           (wr_addr),
    .wr_data           (wr_data),
    .inject_mask       (inject_mask),
    .rd_en             (rd_en),
    .rd_addr           (rd_addr),
    .rd_valid          (rd_valid),
    .rd_data           (rd_data),
    .err_corrected     (err_corrected),
    .err_uncorrectable (err_uncorrectable)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
    end
  end

  // Block by the layout rule, parity at powers of two, data LSB first elsewhere
  function automatic block_t hamming_ref_encode(input data_t data);
    block_t blk;
    int     di;
    logic   p;
    blk = '0;
    di  = 0;
    for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
      if ($countones(pos) != 1) begin
        blk[pos-1] = data[di];
        di++;
      end
    end
    // Parity i covers the other positions with index bit i set
    for (int i = 0; i < PARITY_WIDTH; i++) begin
      p = 1'b0;
      for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
        if (((pos >> i) & 1) == 1 && pos != (1 << i)) begin
          p = p ^ blk[pos-1];
        end
      end
      blk[(1 << i) - 1] = p;
    end
    return blk;
  endfunction

  // Expected {uncorrectable, corrected, data} for a possibly corrupted block
  function automatic logic [DATA_WIDTH+1:0] ref_decode(input block_t blk);
    int     syn;
    logic   recomputed;
    block_t fixed;
    data_t  data;
    int     di;
    logic   corr;
    logic   unc;
    syn = 0;
    for (int i = 0; i < PARITY_WIDTH; i++) begin
      recomputed = 1'b0;
      for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
        if (((pos >> i) & 1) == 1 && pos != (1 << i)) begin
          recomputed = recomputed ^ blk[pos-1];
        end
      end
      // Syndrome bit is recomputed parity XOR stored parity
      if ((recomputed ^ blk[(1 << i) - 1]) == 1'b1) begin
        syn = syn | (1 << i);
      end
    end
    fixed = blk;
    corr  = 1'b0;
    unc   = 1'b0;
    if (syn >= 1 && syn <= BLOCK_WIDTH) begin
      fixed[syn-1] = ~fixed[syn-1];
      corr = 1'b1;
    end else if (syn > BLOCK_WIDTH) begin
      unc = 1'b1;
    end
    data = '0;
    di   = 0;
    for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
      if ($countones(pos) != 1) begin
        data[di] = fixed[pos-1];
        di++;
      end
    end
    return {unc, corr, data};
  endfunction

  task automatic abort_run(input string reason);
    $display("Result: FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
      abort_run("value mismatch");
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // Reads still in the pipeline when reset hits must never come out
  // rd_en stays high through reset so the array valid is exercised too
  task automatic reset_during_reads();
    rd_en = 1'b1;
    for (int a = 0; a < 2; a++) begin
      rd_addr = addr_t'(a);
      @(posedge clk);
      #1;
    end
    apply_reset();
    rd_en = 1'b0;
  endtask

  task automatic write_word(input addr_t addr, input data_t data, input block_t mask);
    wr_en       = 1'b1;
    wr_addr     = addr;
    wr_data     = data;
    inject_mask = mask;
    shadow_mem[addr] = hamming_ref_encode(data) ^ mask;
    @(posedge clk);
    #1;
    wr_en       = 1'b0;
    inject_mask = '0;
  endtask

  // rd_valid arrives three cycles after rd_en is raised
  task automatic issue_read(input addr_t addr);
    rd_en   = 1'b1;
    rd_addr = addr;
    exp_q.push_back(ref_decode(shadow_mem[addr]));
    due_q.push_back(cycle_count + 3);
    @(posedge clk);
    #1;
    rd_en = 1'b0;
  endtask

  // Read and write the same address on one edge, old contents expected
  task automatic write_read_same(input addr_t addr, input data_t data);
    rd_en   = 1'b1;
    rd_addr = addr;
    exp_q.push_back(ref_decode(shadow_mem[addr]));
    due_q.push_back(cycle_count + 3);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    shadow_mem[addr] = hamming_ref_encode(data);
    @(posedge clk);
    #1;
    rd_en = 1'b0;
    wr_en = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Compare process, outputs are stable at the falling edge
  initial begin
    logic [DATA_WIDTH+1:0] expected;
    int                    due;
    forever begin
      @(negedge clk);
      // Flags stay low whenever no result is presented
      if (!rd_valid) begin
        check_value("err_corrected", 32'(err_corrected), 32'd0);
        check_value("err_uncorrectable", 32'(err_uncorrectable), 32'd0);
      end
      if (!rst_n) begin
        check_value("rd_valid", 32'(rd_valid), 32'd0);
      end else if (rd_valid) begin
        if (exp_q.size() == 0) begin
          $display("Error: rd_valid went high with no read outstanding");
          abort_run("unexpected read result");
        end else begin
          expected = exp_q.pop_front();
          due      = due_q.pop_front();
          check_value("rd_valid cycle", 32'(cycle_count), 32'(due));
          check_value("rd_data", 32'(rd_data), 32'(expected[DATA_WIDTH-1:0]));
          check_value("err_corrected", 32'(err_corrected), 32'(expected[DATA_WIDTH]));
          check_value("err_uncorrectable", 32'(err_uncorrectable),
                      32'(expected[DATA_WIDTH+1]));
        end
      end else if (due_q.size() != 0 && cycle_count >= due_q[0]) begin
        $display("Error: a read result did not arrive in its cycle");
        abort_run("missing read result");
      end
    end
  end

  initial begin
    #((NUM_OPS + 50) * CLK_PERIOD);
    $display("Error: timeout, the tests did not finish in time");
    abort_run("watchdog expired");
  end

  initial begin
    data_t  data;
    block_t mask;
    int     b0;
    int     b1;
    void'($urandom(SEED));
    rst_n       = 1'b0;
    wr_en       = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    inject_mask = '0;
    rd_en       = 1'b0;
    rd_addr     = '0;
    apply_reset();

    // Clean round trip over every address
    for (int a = 0; a < MEM_DEPTH; a++) begin
      write_word(addr_t'(a), data_t'($urandom), '0);
    end
    for (int a = 0; a < MEM_DEPTH; a++) begin
      issue_read(addr_t'(a));
    end
    wait_drain();

    // One flipped bit at each block position, parity and data alike
    for (int b = 0; b < BLOCK_WIDTH; b++) begin
      data = data_t'($urandom);
      mask = block_t'(1) << b;
      write_word(addr_t'(b % MEM_DEPTH), data, mask);
      // Model itself must recover the written word
      check_value("ref_decode", 32'(ref_decode(shadow_mem[b % MEM_DEPTH])),
                  32'({2'b01, data}));
      issue_read(addr_t'(b % MEM_DEPTH));
    end
    wait_drain();

    // Two distinct flipped bits, miscorrected or uncorrectable
    for (int n = 0; n < NUM_DOUBLE; n++) begin
      b0   = int'($urandom % BLOCK_WIDTH);
      b1   = (b0 + 1 + int'($urandom % (BLOCK_WIDTH - 1))) % BLOCK_WIDTH;
      mask = (block_t'(1) << b0) | (block_t'(1) << b1);
      write_word(addr_t'(n % MEM_DEPTH), data_t'($urandom), mask);
      issue_read(addr_t'(n % MEM_DEPTH));
    end
    wait_drain();

    // Back-to-back reads, one per cycle
    for (int a = 0; a < MEM_DEPTH; a++) begin
      issue_read(addr_t'(a));
    end
    wait_drain();

    // Same-edge read sees old data, the next read sees new
    write_word(addr_t'(5), 8'h3c, '0);
    write_read_same(addr_t'(5), 8'hc5);
    issue_read(addr_t'(5));
    wait_drain();

    // Reset mid-run with reads in flight, the array must still hold its contents
    reset_during_reads();
    for (int a = 0; a < MEM_DEPTH; a++) begin
      issue_read(addr_t'(a));
    end

    // Last result is due three cycles after the final read
    repeat (4) @(posedge clk);
    if (exp_q.size() != 0) begin
      $display("Error: reads still outstanding at the end of the run");
      abort_run("outstanding reads");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* include/hamming.svh */
`ifndef HAMMING_SVH
`define HAMMING_SVH

// Width helpers for a single-error-correcting Hamming code
// A code with P parity bits covers a block of 2**P - 1 positions

// Smallest parity count P that satisfies 2**P >= D + P + 1
// Covers data widths up to 247 bits, which is plenty for this family
`define GET_HAMMING_PARITY_WIDTH(data_width) \
  (((data_width) <= 1)   ? 2 : \
   ((data_width) <= 4)   ? 3 : \
   ((data_width) <= 11)  ? 4 : \
   ((data_width) <= 26)  ? 5 : \
   ((data_width) <= 57)  ? 6 : \
   ((data_width) <= 120) ? 7 : \
   ((data_width) <= 247) ? 8 : 9)

// Largest data width that P parity bits can protect
// Full-length block minus the parity positions
`define GET_HAMMING_DATA_WIDTH(parity_width) \
  ((2 ** (parity_width)) - (parity_width) - 1)

`endif

/* run.sh */
#!/bin/sh
# Build and run the ECC memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f sources.f \
  --top-module ecc_memory_tb \
  -o ecc_memory_sim

# The exit status of the pipeline is that of tee, the log decides the result
./obj_dir/ecc_memory_sim 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  exit 1
fi
exit 0

/* sources.f */
+incdir+include
design/hamming_pkg.sv
design/hamming_block_packager.sv
design/hamming_encoder.sv
design/ecc_memory_array.sv
design/hamming_syndrome.sv
design/hamming_corrector.sv
design/ecc_memory_top.sv
dv/ecc_memory_tb.sv
